// File: all.f
rob_cfg_pkg.sv
rob_msg_pkg.sv
rob_ptrs.sv
rob_entry_store.sv
rob_branch_check.sv
rob_top.sv
rob_props.sv
rob_tb.sv

// File: run.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb \
	-f all.f -o rob_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q -F '*** TEST FAILED ***' sim.log; then
	exit 1
fi
exit 0

// File: rob_tb.sv
// reorder buffer testbench with stimulus table, clock, reset, watchdog, checks and summary
`default_nettype none

module rob_tb;

	import rob_cfg_pkg::*;
	import rob_msg_pkg::*;

	localparam int PERIOD     = 40;
	localparam int HALF       = PERIOD / 2;
	localparam int RST_CYCLES = 4;
	localparam int MAX_ROWS   = 128;

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_DISPATCH,
		OP_COMPLETE,
		OP_RESOLVE
	} op_e;

	// one cycle of stimulus and the outputs expected before the next rising edge
	typedef struct {
		op_e             op;
		rob_dispatch_t   disp;
		rob_ptr_t        idx;          // complete or resolve index
		logic            taken;
		logic [PC_W-1:0] target;
		logic            exp_rdy;
		rob_retire_t     exp_ret;
		logic            exp_stall;
		logic            exp_halt;
		logic            exp_recover;
		rob_recover_t    exp_info;
		logic            exp_br_right;
		rob_ptr_t        exp_tail;
	} row_t;

	logic          clk;
	logic          rst;
	logic          dispatch_en;
	rob_dispatch_t dispatch;
	logic          complete_en;
	rob_complete_t complete;
	logic          resolve_en;
	rob_resolve_t  resolve;
	logic          retire_rdy;
	rob_retire_t   retire;
	logic          stall;
	logic          halt;
	logic          recover;
	rob_recover_t  recover_info;
	logic          br_right;
	rob_ptr_t      tail;

	row_t     rows [MAX_ROWS];
	int       n_rows;
	rob_ptr_t cur_tail;      // tail expected while the table is built
	integer   seed;
	int       errors;
	int       checks;
	logic     table_ready;
	logic     run_over;

	rob_top UUT (
		.clk            (clk),
		.rst            (rst),
		.dispatch_en_i  (dispatch_en),
		.dispatch_i     (dispatch),
		.complete_en_i  (complete_en),
		.complete_i     (complete),
		.resolve_en_i   (resolve_en),
		.resolve_i      (resolve),
		.retire_rdy_o   (retire_rdy),
		.retire_o       (retire),
		.stall_o        (stall),
		.halt_o         (halt),
		.recover_o      (recover),
		.recover_info_o (recover_info),
		.br_right_o     (br_right),
		.tail_o         (tail)
	);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	// --------------------------------------------------
	// table construction
	// --------------------------------------------------
	// tags and destination follow the row number of the dispatch
	function automatic logic [PRF_TAG_W-1:0] new_tag_of(input int r);
		return PRF_TAG_W'(r % 63);
	endfunction

	function automatic logic [PRF_TAG_W-1:0] old_tag_of(input int r);
		return PRF_TAG_W'((r + 31) % 63);
	endfunction

	function automatic logic [ARCH_REG_W-1:0] ldest_of(input int r);
		return ARCH_REG_W'(r % 31);
	endfunction

	function automatic logic [PC_W-1:0] random_addr();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	task automatic add_row(input op_e op);
		row_t r;
		r.op              = op;
		r.disp            = '0;
		r.idx             = '0;
		r.taken           = 1'b0;
		r.target          = '0;
		r.exp_rdy         = 1'b0;
		r.exp_ret.old_tag = NULL_TAG;   // nothing retiring
		r.exp_ret.new_tag = NULL_TAG;
		r.exp_ret.ldest   = '1;
		r.exp_stall       = 1'b0;
		r.exp_halt        = 1'b0;
		r.exp_recover     = 1'b0;
		r.exp_info        = '0;
		r.exp_br_right    = 1'b0;
		r.exp_tail        = cur_tail;
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic add_dispatch(
		input logic                 br,
		input logic                 pred,
		input logic [PC_W-1:0]      target,
		input logic [BR_MASK_W-1:0] mask,
		input logic [FL_PTR_W-1:0]  fl,
		input logic                 hlt
	);
		rob_dispatch_t d;
		d.new_tag     = new_tag_of(n_rows);
		d.old_tag     = old_tag_of(n_rows);
		d.ldest       = ldest_of(n_rows);
		d.pc          = random_addr();
		d.br_flag     = br;
		d.pred_taken  = pred;
		d.pred_target = target;
		d.br_mask     = mask;
		d.fl_head     = fl;
		d.halt        = hlt;
		add_row(OP_DISPATCH);
		rows[n_rows-1].disp = d;
		cur_tail = cur_tail + ROB_PTR_W'(1);
	endtask

	task automatic add_complete(input rob_ptr_t idx);
		add_row(OP_COMPLETE);
		rows[n_rows-1].idx = idx;
	endtask

	task automatic add_resolve(input rob_ptr_t idx, input logic taken, input logic [PC_W-1:0] t);
		add_row(OP_RESOLVE);
		rows[n_rows-1].idx    = idx;
		rows[n_rows-1].taken  = taken;
		rows[n_rows-1].target = t;
	endtask

	task automatic expect_retire(input int from_row);
		rows[n_rows-1].exp_rdy         = 1'b1;
		rows[n_rows-1].exp_ret.old_tag = old_tag_of(from_row);
		rows[n_rows-1].exp_ret.new_tag = new_tag_of(from_row);
		rows[n_rows-1].exp_ret.ldest   = ldest_of(from_row);
	endtask

	task automatic expect_recovery(input logic [BR_MASK_W-1:0] mask, input logic [FL_PTR_W-1:0] fl);
		rows[n_rows-1].exp_recover      = 1'b1;
		rows[n_rows-1].exp_info.br_mask = mask;
		rows[n_rows-1].exp_info.fl_head = fl;
	endtask

	task automatic build_table();
		int              k;
		int              r_a;
		int              r_br1;
		int              r_x;
		int              r_br2;
		int              r_w;
		int              r_h;
		rob_ptr_t        base;
		rob_ptr_t        br1;
		rob_ptr_t        br2;
		logic [PC_W-1:0] t1;
		logic [PC_W-1:0] t2;
		logic [PC_W-1:0] bad;

		n_rows   = 0;
		cur_tail = '0;

		// fill every slot, then free the head and drain in order
		for (k = 0; k < ROB_DEPTH; k++)
			add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);
		add_row(OP_IDLE);
		rows[n_rows-1].exp_stall = 1'b1;   // tail wrapped to 32
		add_complete('0);
		rows[n_rows-1].exp_stall = 1'b1;
		add_row(OP_IDLE);
		expect_retire(0);                  // stall drops with retire_rdy_o
		for (k = 1; k < ROB_DEPTH; k++) begin
			add_complete(ROB_PTR_W'(k));
			if (k > 1)
				expect_retire(k - 1);
		end
		add_row(OP_IDLE);
		expect_retire(ROB_DEPTH - 1);
		add_row(OP_IDLE);

		// completion order 2, 0, 1 and in order retirement
		base = cur_tail;
		r_a  = n_rows;
		for (k = 0; k < 3; k++)
			add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);
		add_complete(base + ROB_PTR_W'(2));
		add_complete(base);
		add_complete(base + ROB_PTR_W'(1));
		expect_retire(r_a);
		add_row(OP_IDLE);
		expect_retire(r_a + 1);
		add_row(OP_IDLE);
		expect_retire(r_a + 2);
		add_row(OP_IDLE);

		// correctly predicted branch
		br1   = cur_tail;
		r_br1 = n_rows;
		t1    = random_addr();
		add_dispatch(1'b1, 1'b1, t1, 4'b0001, 5'd7, 1'b0);
		r_x = n_rows;
		add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);
		add_resolve(br1, 1'b1, t1);
		rows[n_rows-1].exp_br_right = 1'b1;

		// wrong target with two younger entries
		br2   = cur_tail;
		r_br2 = n_rows;
		t2    = random_addr();
		bad   = t2 ^ 64'h10;
		add_dispatch(1'b1, 1'b0, t2, 4'b0010, 5'd12, 1'b0);
		add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);
		add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);
		add_resolve(br2, 1'b0, bad);
		expect_recovery(4'b0010, 5'd12);
		cur_tail = br2 + ROB_PTR_W'(1);
		add_resolve(br2, 1'b0, bad);       // hold-off cycle
		add_resolve(br2, 1'b0, bad);
		expect_recovery(4'b0010, 5'd12);
		r_w = n_rows;
		add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b0);

		// halt entry reaches the head, then the buffer drains
		r_h = n_rows;
		add_dispatch(1'b0, 1'b0, '0, '0, '0, 1'b1);
		add_complete(br1);
		add_complete(br1 + ROB_PTR_W'(1));
		expect_retire(r_br1);
		add_complete(br2);
		expect_retire(r_x);
		add_complete(br2 + ROB_PTR_W'(1));
		expect_retire(r_br2);
		add_row(OP_IDLE);
		expect_retire(r_w);
		add_row(OP_IDLE);
		rows[n_rows-1].exp_halt = 1'b1;
		add_complete(br2 + ROB_PTR_W'(2));
		rows[n_rows-1].exp_halt = 1'b1;
		add_row(OP_IDLE);
		rows[n_rows-1].exp_halt = 1'b1;
		expect_retire(r_h);
		add_row(OP_IDLE);                  // empty again
	endtask

	// --------------------------------------------------
	// drive and check
	// --------------------------------------------------
	task automatic drive_row(input int i);
		dispatch_en    = (rows[i].op == OP_DISPATCH);
		dispatch       = rows[i].disp;
		complete_en    = (rows[i].op == OP_COMPLETE);
		complete.idx   = rows[i].idx;
		complete.taken = rows[i].taken;
		resolve_en     = (rows[i].op == OP_RESOLVE);
		resolve.idx    = rows[i].idx;
		resolve.taken  = rows[i].taken;
		resolve.target = rows[i].target;
	endtask

	task automatic flag_error(input int i, input string what, input logic [63:0] got,
			input logic [63:0] exp);
		errors++;
		$display("[ERROR] %0t: row %0d, %s is %0h, expected %0h", $time, i, what, got, exp);
	endtask

	task automatic check_row(input int i);
		checks++;
		if (retire_rdy !== rows[i].exp_rdy)
			flag_error(i, "retire_rdy_o", 64'(retire_rdy), 64'(rows[i].exp_rdy));
		if (retire !== rows[i].exp_ret)
			flag_error(i, "retire_o", 64'(retire), 64'(rows[i].exp_ret));
		if (stall !== rows[i].exp_stall)
			flag_error(i, "stall_o", 64'(stall), 64'(rows[i].exp_stall));
		if (halt !== rows[i].exp_halt)
			flag_error(i, "halt_o", 64'(halt), 64'(rows[i].exp_halt));
		if (recover !== rows[i].exp_recover)
			flag_error(i, "recover_o", 64'(recover), 64'(rows[i].exp_recover));
		if (rows[i].exp_recover && recover_info !== rows[i].exp_info)
			flag_error(i, "recover_info_o", 64'(recover_info), 64'(rows[i].exp_info));
		if (br_right !== rows[i].exp_br_right)
			flag_error(i, "br_right_o", 64'(br_right), 64'(rows[i].exp_br_right));
		if (tail !== rows[i].exp_tail)
			flag_error(i, "tail_o", 64'(tail), 64'(rows[i].exp_tail));
	endtask

	initial begin
		int i;
		rst         = 1'b1;
		dispatch_en = 1'b0;
		dispatch    = '0;
		complete_en = 1'b0;
		complete    = '0;
		resolve_en  = 1'b0;
		resolve     = '0;
		errors      = 0;
		checks      = 0;
		run_over    = 1'b0;
		table_ready = 1'b0;
		seed        = 32'hdacf403e;
		build_table();
		table_ready = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (i = 0; i < n_rows; i++) begin
			@(negedge clk);
			drive_row(i);
			#(HALF - 1);    // just before the rising edge
			check_row(i);
		end
		@(negedge clk);
		dispatch_en = 1'b0;
		complete_en = 1'b0;
		resolve_en  = 1'b0;
		run_over    = 1'b1;
		$display("rows: %0d, checks: %0d, errors: %0d", n_rows, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((n_rows + 20) * PERIOD);
		run_over = 1'b1;
		$display("watchdog expired after %0d cycles, the table did not finish", n_rows + 20);
		$display("*** TEST FAILED ***");
		$finish;
	end

	final begin
		if (!run_over)
			$display("*** TEST FAILED ***");
	end

endmodule

`default_nettype wire

// File: rob_props.sv
// concurrent assertions on the reorder buffer pointers and recovery pulse, bound to rob_ptrs
`default_nettype none

module rob_props (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  dispatch_en_i,
	input  wire logic                  retire_i,
	input  wire logic                  recover_i,   // recover_o of the branch check
	input  wire logic                  full_i,
	input  wire rob_cfg_pkg::rob_ptr_t head_i,
	input  wire rob_cfg_pkg::rob_ptr_t tail_i
);

	import rob_cfg_pkg::*;

	rob_ptr_t used;

	assign used = tail_i - head_i;   // occupancy, wrap bit included

	// --------------------------------------------------
	// rules
	// --------------------------------------------------
	no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
		dispatch_en_i |-> !(full_i && !retire_i))
		else $error("dispatch while the buffer is full");

	single_cycle_recover: assert property (@(posedge clk) disable iff (rst)
		recover_i |=> !recover_i)
		else $error("recovery raised in two consecutive cycles");

	head_not_past_tail: assert property (@(posedge clk) disable iff (rst)
		used <= ROB_PTR_W'(ROB_DEPTH))
		else $error("head pointer passed the tail pointer");

endmodule

bind rob_ptrs rob_props u_props (
	.clk           (clk),
	.rst           (rst),
	.dispatch_en_i (dispatch_en_i),
	.retire_i      (retire_i),
	.recover_i     (recover_i),
	.full_i        (full_o),
	.head_i        (head_o),
	.tail_i        (tail_o)
);

`default_nettype wire

// File: rob_top.sv
// reorder buffer top level with pointers, entry store, branch check, retire, stall and halt
`default_nettype none

module rob_top (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        dispatch_en_i,
	input  wire rob_msg_pkg::rob_dispatch_t  dispatch_i,
	input  wire logic                        complete_en_i,
	input  wire rob_msg_pkg::rob_complete_t  complete_i,
	input  wire logic                        resolve_en_i,
	input  wire rob_msg_pkg::rob_resolve_t   resolve_i,
	output logic                             retire_rdy_o,
	output rob_msg_pkg::rob_retire_t         retire_o,
	output logic                             stall_o,
	output logic                             halt_o,
	output logic                             recover_o,
	output rob_msg_pkg::rob_recover_t        recover_info_o,
	output logic                             br_right_o,
	output rob_cfg_pkg::rob_ptr_t            tail_o
);

	import rob_cfg_pkg::*;
	import rob_msg_pkg::*;

	rob_ptr_t   head;
	rob_ptr_t   tail;
	logic       empty;
	logic       full;
	rob_entry_t head_entry;
	rob_entry_t resolve_entry;

	// --------------------------------------------------
	// blocks
	// --------------------------------------------------
	rob_ptrs u_ptrs (
		.clk           (clk),
		.rst           (rst),
		.dispatch_en_i (dispatch_en_i),
		.retire_i      (retire_rdy_o),
		.recover_i     (recover_o),      // wins over dispatch
		.recover_idx_i (resolve_i.idx),
		.head_o        (head),
		.tail_o        (tail),
		.empty_o       (empty),
		.full_o        (full)
	);

	rob_entry_store u_store (
		.clk             (clk),
		.rst             (rst),
		.head_i          (head),
		.tail_i          (tail),
		.dispatch_en_i   (dispatch_en_i),
		.dispatch_i      (dispatch_i),
		.complete_en_i   (complete_en_i),
		.complete_i      (complete_i),
		.resolve_idx_i   (resolve_i.idx),
		.head_entry_o    (head_entry),
		.resolve_entry_o (resolve_entry),
		.retire_rdy_o    (retire_rdy_o)
	);

	rob_branch_check u_br_check (
		.clk            (clk),
		.rst            (rst),
		.resolve_en_i   (resolve_en_i),
		.resolve_i      (resolve_i),
		.entry_i        (resolve_entry),
		.outcome_o      (),
		.recover_o      (recover_o),
		.recover_info_o (recover_info_o),
		.br_right_o     (br_right_o)
	);

	// --------------------------------------------------
	// retire payload, stall and halt
	// --------------------------------------------------
	always_comb begin
		if (retire_rdy_o) begin
			retire_o.old_tag = head_entry.disp.old_tag;
			retire_o.new_tag = head_entry.disp.new_tag;
			retire_o.ldest   = head_entry.disp.ldest;
		end else begin
			retire_o.old_tag = NULL_TAG;  // nothing retiring
			retire_o.new_tag = NULL_TAG;
			retire_o.ldest   = '1;
		end
	end

	assign stall_o = full && !retire_rdy_o;       // a retiring head frees a slot
	assign halt_o  = !empty && head_entry.disp.halt;
	assign tail_o  = tail;

endmodule

`default_nettype wire

// File: rob_branch_check.sv
// branch misprediction compare, recovery outputs and one-cycle recovery hold-off
`default_nettype none

module rob_branch_check (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        resolve_en_i,
	input  wire rob_msg_pkg::rob_resolve_t   resolve_i,
	input  wire rob_msg_pkg::rob_entry_t     entry_i,    // entry at resolve index
	output rob_msg_pkg::br_outcome_e         outcome_o,
	output logic                             recover_o,
	output rob_msg_pkg::rob_recover_t        recover_info_o,
	output logic                             br_right_o
);

	import rob_msg_pkg::*;

	logic mispredict;
	logic holdoff_r;  // set in the cycle after a recovery

	// --------------------------------------------------
	// compare with the prediction saved at dispatch
	// --------------------------------------------------
	assign mispredict = (resolve_i.taken != entry_i.disp.pred_taken) ||
	                    (resolve_i.target != entry_i.disp.pred_target);

	always_comb begin
		if (!resolve_en_i || !entry_i.disp.br_flag)
			outcome_o = BR_NONE;
		else if (mispredict)
			outcome_o = BR_WRONG;
		else
			outcome_o = BR_RIGHT;
	end

	assign br_right_o = (outcome_o == BR_RIGHT);
	assign recover_o  = (outcome_o == BR_WRONG) && !holdoff_r;

	// mask and free list head go out only with the recovery pulse
	always_comb begin
		recover_info_o = '0;
		if (recover_o) begin
			recover_info_o.br_mask = entry_i.disp.br_mask;
			recover_info_o.fl_head = entry_i.disp.fl_head;
		end
	end

	// --------------------------------------------------
	// hold-off
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			holdoff_r <= 1'b0;
		else
			holdoff_r <= recover_o;  // one cycle only
	end

endmodule

`default_nettype wire

// File: rob_entry_store.sv
// reorder buffer entry array with tail write, completion marking, head clear and read ports
`default_nettype none

module rob_entry_store (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire rob_cfg_pkg::rob_ptr_t        head_i,
	input  wire rob_cfg_pkg::rob_ptr_t        tail_i,
	input  wire logic                         dispatch_en_i,
	input  wire rob_msg_pkg::rob_dispatch_t   dispatch_i,
	input  wire logic                         complete_en_i,
	input  wire rob_msg_pkg::rob_complete_t   complete_i,
	input  wire rob_cfg_pkg::rob_ptr_t        resolve_idx_i,
	output rob_msg_pkg::rob_entry_t           head_entry_o,
	output rob_msg_pkg::rob_entry_t           resolve_entry_o,
	output logic                              retire_rdy_o
);

	import rob_cfg_pkg::*;
	import rob_msg_pkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	rob_dispatch_t          payload_r [ROB_DEPTH];  // tags, pc, branch info
	logic [ROB_DEPTH-1:0]   done_r;                 // per slot status
	logic [ROB_DEPTH-1:0]   taken_r;

	rob_dispatch_t cleared;
	rob_idx_t      head_idx;
	rob_idx_t      tail_idx;
	rob_idx_t      cmp_idx;
	rob_idx_t      res_idx;

	assign head_idx = head_i[ROB_IDX_W-1:0];
	assign tail_idx = tail_i[ROB_IDX_W-1:0];
	assign cmp_idx  = complete_i.idx[ROB_IDX_W-1:0];
	assign res_idx  = resolve_idx_i[ROB_IDX_W-1:0];

	// a rolled back slot can still hold a stale done bit,
	// so an empty buffer never reports a ready head
	assign retire_rdy_o = done_r[head_idx] && (head_i != tail_i);

	// value left behind by a retiring entry
	always_comb begin
		cleared         = '0;
		cleared.new_tag = NULL_TAG;
		cleared.old_tag = NULL_TAG;
		cleared.ldest   = '1;
	end

	// --------------------------------------------------
	// payload writes
	// --------------------------------------------------
	// tail write comes last so a full buffer can refill the retiring slot
	always_ff @(posedge clk) begin
		if (retire_rdy_o)
			payload_r[head_idx] <= cleared;
		if (dispatch_en_i)
			payload_r[tail_idx] <= dispatch_i;
	end

	// --------------------------------------------------
	// status writes
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			done_r  <= '0;
			taken_r <= '0;
		end else begin
			if (retire_rdy_o) begin
				done_r[head_idx]  <= 1'b0;
				taken_r[head_idx] <= 1'b0;
			end
			if (dispatch_en_i) begin
				done_r[tail_idx]  <= 1'b0;  // new entry starts busy
				taken_r[tail_idx] <= 1'b0;
			end
			if (complete_en_i) begin
				// completion beats clear and allocate on the same slot
				done_r[cmp_idx]  <= 1'b1;
				taken_r[cmp_idx] <= complete_i.taken;
			end
		end
	end

	// --------------------------------------------------
	// read ports
	// --------------------------------------------------
	always_comb begin
		head_entry_o.disp      = payload_r[head_idx];
		head_entry_o.done      = done_r[head_idx];
		head_entry_o.act_taken = taken_r[head_idx];
	end

	always_comb begin
		resolve_entry_o.disp      = payload_r[res_idx];  // branch under resolve
		resolve_entry_o.done      = done_r[res_idx];
		resolve_entry_o.act_taken = taken_r[res_idx];
	end

endmodule

`default_nettype wire

// File: rob_ptrs.sv
// head and tail pointers with wrap bit, empty and full flags, tail rollback on recovery
`default_nettype none

module rob_ptrs (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  dispatch_en_i,  // allocate one slot
	input  wire logic                  retire_i,       // head slot leaves
	input  wire logic                  recover_i,
	input  wire rob_cfg_pkg::rob_ptr_t recover_idx_i,  // mispredicted branch
	output rob_cfg_pkg::rob_ptr_t      head_o,
	output rob_cfg_pkg::rob_ptr_t      tail_o,
	output logic                       empty_o,
	output logic                       full_o
);

	import rob_cfg_pkg::*;

	rob_ptr_t head_r;
	rob_ptr_t tail_r;
	rob_ptr_t head_nxt;
	rob_ptr_t tail_nxt;
	rob_ptr_t ptr_diff;

	// --------------------------------------------------
	// occupancy
	// --------------------------------------------------
	// same slot, same lap -> empty; same slot, other lap -> full
	assign ptr_diff = head_r ^ tail_r;
	assign empty_o  = (ptr_diff == '0);
	assign full_o   = (ptr_diff == {1'b1, {ROB_IDX_W{1'b0}}});

	assign head_o = head_r;
	assign tail_o = tail_r;

	// --------------------------------------------------
	// next pointer values
	// --------------------------------------------------
	always_comb begin
		head_nxt = head_r;
		if (retire_i)
			head_nxt = head_r + 1'b1;
	end

	always_comb begin
		tail_nxt = tail_r;
		if (recover_i) begin
			// drop everything younger than the branch
			tail_nxt = recover_idx_i + 1'b1;
		end else if (dispatch_en_i) begin
			tail_nxt = tail_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			head_r <= head_nxt;
			tail_r <= tail_nxt;
		end
	end

endmodule

`default_nettype wire

// File: rob_msg_pkg.sv
// packed structs and branch outcome enum passed between reorder buffer blocks
`default_nettype none

package rob_msg_pkg;

	import rob_cfg_pkg::*;

	// --------------------------------------------------
	// dispatch side
	// --------------------------------------------------
	typedef struct packed {
		logic [PRF_TAG_W-1:0]  new_tag;      // from free list
		logic [PRF_TAG_W-1:0]  old_tag;      // from map table
		logic [ARCH_REG_W-1:0] ldest;
		logic [PC_W-1:0]       pc;
		logic                  br_flag;
		logic                  pred_taken;
		logic [PC_W-1:0]       pred_target;
		logic [BR_MASK_W-1:0]  br_mask;
		logic [FL_PTR_W-1:0]   fl_head;      // free list head at dispatch
		logic                  halt;
	} rob_dispatch_t;

	typedef struct packed {
		rob_dispatch_t disp;
		logic          done;
		logic          act_taken;  // direction reported at completion
	} rob_entry_t;

	// --------------------------------------------------
	// functional unit side
	// --------------------------------------------------
	typedef struct packed {
		rob_ptr_t idx;
		logic     taken;
	} rob_complete_t;

	typedef struct packed {
		rob_ptr_t        idx;
		logic            taken;
		logic [PC_W-1:0] target;
	} rob_resolve_t;

	// --------------------------------------------------
	// retire and recovery side
	// --------------------------------------------------
	typedef struct packed {
		logic [PRF_TAG_W-1:0]  old_tag;  // back to free list
		logic [PRF_TAG_W-1:0]  new_tag;  // into arch map
		logic [ARCH_REG_W-1:0] ldest;
	} rob_retire_t;

	typedef struct packed {
		logic [BR_MASK_W-1:0] br_mask;
		logic [FL_PTR_W-1:0]  fl_head;
	} rob_recover_t;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_RIGHT,
		BR_WRONG
	} br_outcome_e;

endpackage

`default_nettype wire

// File: rob_cfg_pkg.sv
// reorder buffer geometry, field widths, null tag and pointer types
`default_nettype none

package rob_cfg_pkg;

	// --------------------------------------------------
	// buffer geometry
	// --------------------------------------------------
	localparam int ROB_DEPTH  = 32;
	localparam int ROB_IDX_W  = 5;              // log2 of depth
	localparam int ROB_PTR_W  = ROB_IDX_W + 1;  // extra wrap bit

	// --------------------------------------------------
	// field widths
	// --------------------------------------------------
	localparam int PRF_TAG_W  = 6;   // physical register tag
	localparam int ARCH_REG_W = 5;   // logical register number
	localparam int FL_PTR_W   = 5;   // free list head
	localparam int BR_MASK_W  = 4;
	localparam int PC_W       = 64;

	// a retired or never used slot carries this tag
	localparam logic [PRF_TAG_W-1:0] NULL_TAG = '1;

	// wrap bit is the msb, the low bits select the slot
	typedef logic [ROB_PTR_W-1:0] rob_ptr_t;
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;

endpackage

`default_nettype wire
